// File: cl_top.f
+incdir+.
cl_pkg.sv
cl_status.sv
cl_host_slice.sv
cl_host_decode.sv
cl_config_rom.sv
cl_mem_arbiter.sv
cl_top.sv
tb_cl_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the cl_top testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_cl_top -f cl_top.f -o tb_cl_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/tb_cl_top > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
exit 1

// File: tb_cl_top.sv
/* Testbench for cl_top with a host register table, a memory model with random
   back-pressure, two memory request streams and a watchdog */
`timescale 1ns/1ps
`default_nettype none

`include "cl_consts.svh"

module tb_cl_top;

  localparam int          CLK_NS    = 4;
  localparam int          HOST_ROWS = 20;
  localparam int          MEM_N     = 8;
  localparam logic [15:0] LFSR_SEED = 16'd54753;
  localparam logic [15:0] DIP_VAL   = 16'h5A3C;

  // One host transaction with its expected response
  typedef struct packed {
    logic [15:0] addr;
    logic        write;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
  } host_row_t;

  logic                   clk_main_a0;
  logic                   rst_main_n_sync;
  logic                   host_req_valid_i;
  cl_pkg::host_req_t      host_req_i;
  logic                   host_req_ready_o;
  logic                   host_rsp_valid_o;
  cl_pkg::host_rsp_t      host_rsp_o;
  logic                   host_rsp_ready_i;
  logic [15:0]            status_vdip_i;
  logic [15:0]            status_vled_o;
  // Slot 0 is DMA, slot 1 is the accelerator
  logic [1:0]             req_valid;
  cl_pkg::mem_req_t [1:0] req_d;
  logic [1:0]             req_ready;
  logic [1:0]             rsp_valid;
  cl_pkg::mem_rsp_t [1:0] rsp_d;
  logic [1:0]             rsp_ready;
  logic                   mem_req_valid_o;
  cl_pkg::mem_req_t       mem_req_o;
  logic                   mem_req_ready_i;
  logic                   mem_rsp_valid_i;
  cl_pkg::mem_rsp_t       mem_rsp_i;
  logic                   mem_rsp_ready_o;

  host_row_t   rows [HOST_ROWS];
  int          n_rows;
  int          n_tests;
  int          n_failed;
  int          n_mismatch;
  int          mem_bad [2];
  logic [15:0] host_lfsr;

  cl_top uut (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req_i),
    .host_req_ready_o (host_req_ready_o),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rsp_o       (host_rsp_o),
    .host_rsp_ready_i (host_rsp_ready_i),
    .status_vdip_i    (status_vdip_i),
    .status_vled_o    (status_vled_o),
    .dma_req_valid_i  (req_valid[0]),
    .dma_req_i        (req_d[0]),
    .dma_req_ready_o  (req_ready[0]),
    .dma_rsp_valid_o  (rsp_valid[0]),
    .dma_rsp_o        (rsp_d[0]),
    .dma_rsp_ready_i  (rsp_ready[0]),
    .accel_req_valid_i(req_valid[1]),
    .accel_req_i      (req_d[1]),
    .accel_req_ready_o(req_ready[1]),
    .accel_rsp_valid_o(rsp_valid[1]),
    .accel_rsp_o      (rsp_d[1]),
    .accel_rsp_ready_i(rsp_ready[1]),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_i        (mem_rsp_i),
    .mem_rsp_ready_o  (mem_rsp_ready_o)
  );

  always #(CLK_NS / 2) clk_main_a0 = ~clk_main_a0;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bit(inout logic [15:0] st, output logic b);
    b  = st[0];
    st = lfsr_step(st);
  endtask

  // Region in the top two bits, select or index in the low byte
  function automatic logic [15:0] host_addr(input logic [1:0] region, input logic [7:0] low);
    return {region, 6'b000000, low};
  endfunction

  function automatic logic [31:0] mem_addr(input logic s, input int k);
    return 32'h4000_0000 + 32'(s) * 32'h0100_0000 + 32'(k) * 32'd8;
  endfunction

  function automatic logic [3:0] mem_tag(input logic s, input int k);
    return 4'(32'(s) * MEM_N + k);
  endfunction

  task automatic add_row(input logic [15:0] a, input logic w, input logic [31:0] wd,
                         input logic [31:0] rd, input logic e);
    rows[n_rows] = '{addr: a, write: w, wdata: wd, rdata: rd, err: e};
    n_rows++;
  endtask

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    n_mismatch++;
  endtask

  task automatic close_test(input string name, input int errs);
    n_tests++;
    if (errs != 0) begin
      n_failed++;
      $display("%s: failed with %0d errors", name, errs);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // Send one host request, then wait for its response under random ready
  task automatic host_xfer(input host_row_t r, output cl_pkg::host_rsp_t got);
    cl_pkg::host_rsp_t held;
    logic              held_v;
    logic              done;
    logic              b;
    @(negedge clk_main_a0);
    host_req_valid_i = 1'b1;
    host_req_i       = {r.addr, r.wdata, r.write};
    @(posedge clk_main_a0);
    while (!host_req_ready_o) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    host_req_valid_i = 1'b0;
    held_v = 1'b0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk_main_a0);
      if (host_rsp_valid_o) begin
        if (held_v && host_rsp_o !== held) begin
          flag_mismatch($sformatf("host response changed while waiting, %h then %h",
                                  held, host_rsp_o));
        end
        if (host_rsp_ready_i) begin
          got  = host_rsp_o;
          done = 1'b1;
        end
        held   = host_rsp_o;
        held_v = 1'b1;
      end
      @(negedge clk_main_a0);
      take_bit(host_lfsr, b);
      host_rsp_ready_i = b;
    end
  endtask

  // ----------------------------------------
  // Memory requesters
  // ----------------------------------------
  task automatic issue_stream(input logic s);
    for (int k = 0; k < MEM_N; k++) begin
      @(negedge clk_main_a0);
      req_valid[s]   = 1'b1;
      req_d[s].addr  = mem_addr(s, k);
      req_d[s].wdata = '0;
      req_d[s].write = 1'b0;
      req_d[s].tag   = mem_tag(s, k);
      @(posedge clk_main_a0);
      while (!req_ready[s]) @(posedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    req_valid[s] = 1'b0;
  endtask

  task automatic collect_stream(input logic s);
    int               k;
    cl_pkg::mem_rsp_t exp;
    k = 0;
    while (k < MEM_N) begin
      @(posedge clk_main_a0);
      if (rsp_valid[s] && rsp_ready[s]) begin
        // Memory answers with the address twice and the request tag
        exp.rdata = {mem_addr(s, k), mem_addr(s, k)};
        exp.tag   = mem_tag(s, k);
        if (rsp_d[s] !== exp) begin
          flag_mismatch($sformatf("requester %0d response %0d got %h tag %h, expected %h tag %h",
                                  s, k, rsp_d[s].rdata, rsp_d[s].tag, exp.rdata, exp.tag));
          mem_bad[s]++;
        end
        k++;
      end
    end
  endtask

  // ----------------------------------------
  // Memory model, in-order with random delay and requester back-pressure
  // ----------------------------------------
  initial begin : mem_model
    cl_pkg::mem_req_t pend [$];
    logic [15:0]      st;
    logic             b0;
    logic             b1;
    logic             took;
    int               delay;
    st              = LFSR_SEED;
    delay           = 0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    forever begin
      @(posedge clk_main_a0);
      took = mem_rsp_valid_i && mem_rsp_ready_o;
      if (rst_main_n_sync && mem_req_valid_o && mem_req_ready_i) begin
        pend.push_back(mem_req_o);
      end
      @(negedge clk_main_a0);
      if (took) begin
        void'(pend.pop_front());
        mem_rsp_valid_i = 1'b0;
      end
      take_bit(st, b0);
      mem_req_ready_i = b0;
      // Each requester takes its own bit for response ready
      take_bit(st, b0);
      rsp_ready[0] = b0;
      take_bit(st, b0);
      rsp_ready[1] = b0;
      if (!mem_rsp_valid_i && pend.size() > 0) begin
        if (delay == 0) begin
          mem_rsp_valid_i = 1'b1;
          mem_rsp_i.rdata = {pend[0].addr, pend[0].addr};
          mem_rsp_i.tag   = pend[0].tag;
          take_bit(st, b0);
          take_bit(st, b1);
          delay = int'({b1, b0});
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin : watchdog
    #((HOST_ROWS * 200 + 2 * MEM_N * 50) * CLK_NS);
    $display("Watchdog expired before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    cl_pkg::host_rsp_t got;
    int                bad_before;
    clk_main_a0      = 1'b0;
    rst_main_n_sync  = 1'b0;
    host_req_valid_i = 1'b0;
    host_req_i       = '0;
    host_rsp_ready_i = 1'b0;
    status_vdip_i    = '0;
    req_valid        = '0;
    req_d            = '0;
    rsp_ready        = '0;
    host_lfsr        = LFSR_SEED;
    n_rows           = 0;
    n_tests          = 0;
    n_failed         = 0;
    n_mismatch       = 0;
    mem_bad[0]       = 0;
    mem_bad[1]       = 0;

    add_row(host_addr(cl_pkg::REGION_CSR, 8'd0), 1'b0, '0, `CL_ID0, 1'b0);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd1), 1'b0, '0, `CL_ID1, 1'b0);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd3), 1'b0, '0, {16'h0000, `CL_VLED_PATTERN}, 1'b0);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd2), 1'b0, '0, {16'h0000, DIP_VAL}, 1'b0);
    add_row(host_addr(cl_pkg::REGION_ROM, 8'd0), 1'b0, '0, {`CL_ROM_TAG, 16'd0}, 1'b0);
    add_row(host_addr(cl_pkg::REGION_ROM, 8'd7), 1'b0, '0, {`CL_ROM_TAG, 16'd7}, 1'b0);
    add_row(host_addr(cl_pkg::REGION_ROM, 8'd31), 1'b0, '0, {`CL_ROM_TAG, 16'd31}, 1'b0);
    add_row(host_addr(cl_pkg::REGION_ROM, 8'd32), 1'b0, '0, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_ROM, 8'd255), 1'b0, '0, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd4), 1'b1, 32'hA5A5_5A5A, '0, 1'b0);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd4), 1'b0, '0, 32'hA5A5_5A5A, 1'b0);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd0), 1'b1, 32'h1111_2222, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_ROM, 8'd3), 1'b1, 32'h3333_4444, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd5), 1'b0, '0, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd15), 1'b0, '0, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd5), 1'b1, 32'h5555_6666, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_UNMAP_A, 8'd0), 1'b0, '0, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_UNMAP_B, 8'd4), 1'b1, 32'h7777_8888, '0, 1'b1);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd4), 1'b1, 32'h0BAD_CAFE, '0, 1'b0);
    add_row(host_addr(cl_pkg::REGION_CSR, 8'd4), 1'b0, '0, 32'h0BAD_CAFE, 1'b0);

    repeat (4) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    status_vdip_i   = DIP_VAL;
    // DIP needs two edges through the synchronizer, LED two edges after reset
    repeat (3) @(negedge clk_main_a0);
    bad_before = n_mismatch;
    if (status_vled_o !== `CL_VLED_PATTERN) begin
      flag_mismatch($sformatf("status_vled_o %h, expected %h", status_vled_o, `CL_VLED_PATTERN));
    end
    if (host_rsp_valid_o !== 1'b0 || host_req_ready_o !== 1'b1) begin
      flag_mismatch("host port not idle after reset");
    end
    close_test("status after reset", n_mismatch - bad_before);

    for (int i = 0; i < HOST_ROWS; i++) begin
      bad_before = n_mismatch;
      host_xfer(rows[i], got);
      if (got.err !== rows[i].err) begin
        flag_mismatch($sformatf("row %0d err %b, expected %b", i, got.err, rows[i].err));
      end
      if (!rows[i].err && got.rdata !== rows[i].rdata) begin
        flag_mismatch($sformatf("row %0d rdata %h, expected %h", i, got.rdata, rows[i].rdata));
      end
      close_test($sformatf("host row %0d addr %h", i, rows[i].addr), n_mismatch - bad_before);
    end

    fork
      issue_stream(1'b0);
      issue_stream(1'b1);
      collect_stream(1'b0);
      collect_stream(1'b1);
    join
    close_test("dma memory stream", mem_bad[0]);
    close_test("accel memory stream", mem_bad[1]);

    $display("%0d tests, %0d failed, %0d mismatches", n_tests, n_failed, n_mismatch);
    if (n_failed == 0 && n_mismatch == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cl_top.sv
/* Top level with status block, host register path and shared memory arbiter */
`timescale 1ns/1ps
`default_nettype none

module cl_top (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  // Host register port
  input  logic              host_req_valid_i,
  input  cl_pkg::host_req_t host_req_i,
  output logic              host_req_ready_o,
  output logic              host_rsp_valid_o,
  output cl_pkg::host_rsp_t host_rsp_o,
  input  logic              host_rsp_ready_i,
  // Virtual DIP and LED
  input  logic [15:0]       status_vdip_i,
  output logic [15:0]       status_vled_o,
  // DMA requester
  input  logic              dma_req_valid_i,
  input  cl_pkg::mem_req_t  dma_req_i,
  output logic              dma_req_ready_o,
  output logic              dma_rsp_valid_o,
  output cl_pkg::mem_rsp_t  dma_rsp_o,
  input  logic              dma_rsp_ready_i,
  // Accelerator requester
  input  logic              accel_req_valid_i,
  input  cl_pkg::mem_req_t  accel_req_i,
  output logic              accel_req_ready_o,
  output logic              accel_rsp_valid_o,
  output cl_pkg::mem_rsp_t  accel_rsp_o,
  input  logic              accel_rsp_ready_i,
  // Memory port
  output logic              mem_req_valid_o,
  output cl_pkg::mem_req_t  mem_req_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_rsp_valid_i,
  input  cl_pkg::mem_rsp_t  mem_rsp_i,
  output logic              mem_rsp_ready_o
);

  logic [15:0]       vdip_sync;
  logic              slc_valid;
  cl_pkg::host_req_t slc_req;
  logic              slc_ready;
  logic [7:0]        rom_index;
  logic [31:0]       rom_data;
  logic              rom_hit;

  cl_status u_status (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .status_vdip_i  (status_vdip_i),
    .status_vled_o  (status_vled_o),
    .vdip_sync_o    (vdip_sync)
  );

  // ----------------------------------------
  // Host register path
  // ----------------------------------------
  cl_host_slice u_host_slice (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .s_valid_i      (host_req_valid_i),
    .s_req_i        (host_req_i),
    .s_ready_o      (host_req_ready_o),
    .m_valid_o      (slc_valid),
    .m_req_o        (slc_req),
    .m_ready_i      (slc_ready)
  );

  cl_host_decode u_host_decode (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .req_valid_i    (slc_valid),
    .req_i          (slc_req),
    .req_ready_o    (slc_ready),
    .rsp_valid_o    (host_rsp_valid_o),
    .rsp_o          (host_rsp_o),
    .rsp_ready_i    (host_rsp_ready_i),
    .vdip_i         (vdip_sync),
    .vled_i         (status_vled_o),
    .rom_index_o    (rom_index),
    .rom_data_i     (rom_data),
    .rom_hit_i      (rom_hit)
  );

  cl_config_rom u_config_rom (
    .clk_main_a0(clk_main_a0),
    .index_i    (rom_index),
    .data_o     (rom_data),
    .hit_o      (rom_hit)
  );

  // ----------------------------------------
  // Shared memory path, DMA on slot 0
  // ----------------------------------------
  cl_mem_arbiter u_mem_arbiter (
    .clk_main_a0    (clk_main_a0),
    .rst_main_n_sync(rst_main_n_sync),
    .req_valid_i    ({accel_req_valid_i, dma_req_valid_i}),
    .req_i          ({accel_req_i, dma_req_i}),
    .req_ready_o    ({accel_req_ready_o, dma_req_ready_o}),
    .rsp_valid_o    ({accel_rsp_valid_o, dma_rsp_valid_o}),
    .rsp_o          ({accel_rsp_o, dma_rsp_o}),
    .rsp_ready_i    ({accel_rsp_ready_i, dma_rsp_ready_i}),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_i      (mem_rsp_i),
    .mem_rsp_ready_o(mem_rsp_ready_o)
  );

endmodule

`default_nettype wire

// File: cl_mem_arbiter.sv
/* Round-robin 2:1 memory arbiter with in-order response steering */
`timescale 1ns/1ps
`default_nettype none

`include "cl_consts.svh"

module cl_mem_arbiter (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  // Requesters, 0 is DMA and 1 is the accelerator
  input  logic [1:0]             req_valid_i,
  input  cl_pkg::mem_req_t [1:0] req_i,
  output logic [1:0]             req_ready_o,
  output logic [1:0]             rsp_valid_o,
  output cl_pkg::mem_rsp_t [1:0] rsp_o,
  input  logic [1:0]             rsp_ready_i,
  // Shared memory port
  output logic                   mem_req_valid_o,
  output cl_pkg::mem_req_t       mem_req_o,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_rsp_valid_i,
  input  cl_pkg::mem_rsp_t       mem_rsp_i,
  output logic                   mem_rsp_ready_o
);

  localparam int DEPTH = `CL_MEM_ISSUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic             src_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             rr_q;
  logic             gnt_sel;
  logic             full;
  logic             q_empty;
  logic             can_issue;
  logic             issue;
  logic             pop;
  logic             head_src;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  assign full      = count_q == CNT_W'(DEPTH);
  assign q_empty   = count_q == '0;
  // Pointer picks only when both want the port
  assign gnt_sel   = (&req_valid_i) ? rr_q : req_valid_i[1];
  assign can_issue = !full && mem_req_ready_i;

  assign req_ready_o[0]  = can_issue && !gnt_sel;
  assign req_ready_o[1]  = can_issue && gnt_sel;
  assign mem_req_valid_o = (|req_valid_i) && !full;
  assign mem_req_o       = req_i[gnt_sel];
  assign issue           = mem_req_valid_o && mem_req_ready_i;

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  assign head_src        = src_q[rd_ptr_q];
  assign rsp_valid_o[0]  = mem_rsp_valid_i && !q_empty && !head_src;
  assign rsp_valid_o[1]  = mem_rsp_valid_i && !q_empty && head_src;
  assign rsp_o[0]        = mem_rsp_i;
  assign rsp_o[1]        = mem_rsp_i;
  // Owner back-pressure reaches the memory port
  assign mem_rsp_ready_o = rsp_ready_i[head_src];
  assign pop             = mem_rsp_valid_i && mem_rsp_ready_o && !q_empty;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      rr_q     <= 1'b0;
    end else begin
      if (issue) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        rr_q     <= !gnt_sel;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(issue) - CNT_W'(pop);
    end
  end

  // Source of each issued request, oldest at the read pointer
  always_ff @(posedge clk_main_a0) begin
    if (issue) begin
      src_q[wr_ptr_q] <= gnt_sel;
    end
  end

  a_no_orphan_rsp: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    mem_rsp_valid_i |-> !q_empty);

  a_depth_bound: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    count_q <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: cl_config_rom.sv
/* Configuration ROM with registered read and range hit */
`timescale 1ns/1ps
`default_nettype none

`include "cl_consts.svh"

module cl_config_rom (
  input  logic        clk_main_a0,
  input  logic [7:0]  index_i,
  output logic [31:0] data_o,
  output logic        hit_o
);

  localparam int ROM_AW = $clog2(`CL_ROM_ELS);

  logic [31:0] rom_words [`CL_ROM_ELS];

  // Tag in the upper half, word number in the lower half
  for (genvar i = 0; i < `CL_ROM_ELS; i++) begin : g_word
    assign rom_words[i] = {`CL_ROM_TAG, 16'(i)};
  end

  always_ff @(posedge clk_main_a0) begin
    data_o <= rom_words[index_i[ROM_AW-1:0]];
    hit_o  <= 32'(index_i) < `CL_ROM_ELS;
  end

endmodule

`default_nettype wire

// File: cl_host_decode.sv
/* Host region decoder with ROM, ID, status and scratch access and a held response */
`timescale 1ns/1ps
`default_nettype none

`include "cl_consts.svh"

module cl_host_decode (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              req_valid_i,
  input  cl_pkg::host_req_t req_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output cl_pkg::host_rsp_t rsp_o,
  input  logic              rsp_ready_i,
  input  logic [15:0]       vdip_i,
  input  logic [15:0]       vled_i,
  output logic [7:0]        rom_index_o,
  input  logic [31:0]       rom_data_i,
  input  logic              rom_hit_i
);

  logic                       s1_valid_q;
  cl_pkg::host_req_t          s1_req_q;
  cl_pkg::host_rsp_t          rsp_d;
  cl_pkg::host_rsp_t          rsp_q;
  logic                       rsp_valid_q;
  logic [`CL_HOST_DATA_W-1:0] scratch_q;
  logic                       scratch_we;
  logic [3:0]                 reg_sel;
  logic                       req_fire;

  // One request in the lookup stage at a time
  assign req_ready_o = !s1_valid_q && (!rsp_valid_q || rsp_ready_i);
  assign req_fire    = req_valid_i && req_ready_o;
  // ROM sees the index as the request is taken
  assign rom_index_o = req_i.addr.rom_view.index;
  assign reg_sel     = s1_req_q.addr.csr_view.reg_sel;

  // ----------------------------------------
  // Region decode of the lookup stage
  // ----------------------------------------
  always_comb begin
    rsp_d      = '0;
    scratch_we = 1'b0;
    case (s1_req_q.addr.csr_view.region)
      cl_pkg::REGION_ROM: begin
        if (s1_req_q.write) begin
          rsp_d.err = 1'b1;
        end else begin
          rsp_d.rdata = rom_hit_i ? rom_data_i : '0;
          rsp_d.err   = !rom_hit_i;
        end
      end
      cl_pkg::REGION_CSR: begin
        if (s1_req_q.write) begin
          if (reg_sel == cl_pkg::CSR_SCRATCH) begin
            scratch_we = s1_valid_q;
          end else begin
            rsp_d.err = 1'b1;
          end
        end else begin
          case (reg_sel)
            cl_pkg::CSR_ID0:     rsp_d.rdata = `CL_ID0;
            cl_pkg::CSR_ID1:     rsp_d.rdata = `CL_ID1;
            cl_pkg::CSR_DIP:     rsp_d.rdata = `CL_HOST_DATA_W'(vdip_i);
            cl_pkg::CSR_LED:     rsp_d.rdata = `CL_HOST_DATA_W'(vled_i);
            cl_pkg::CSR_SCRATCH: rsp_d.rdata = scratch_q;
            default:             rsp_d.err   = 1'b1;
          endcase
        end
      end
      default: rsp_d.err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      s1_valid_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
      scratch_q   <= '0;
    end else begin
      s1_valid_q <= req_fire;
      if (s1_valid_q) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (scratch_we) begin
        scratch_q <= s1_req_q.wdata;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge clk_main_a0) begin
    if (req_fire) begin
      s1_req_q <= req_i;
    end
    if (s1_valid_q) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  a_rsp_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

`default_nettype wire

// File: cl_host_slice.sv
/* Single-entry register slice for the host request channel */
`timescale 1ns/1ps
`default_nettype none

module cl_host_slice (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  // Upstream side
  input  logic              s_valid_i,
  input  cl_pkg::host_req_t s_req_i,
  output logic              s_ready_o,
  // Downstream side
  output logic              m_valid_o,
  output cl_pkg::host_req_t m_req_o,
  input  logic              m_ready_i
);

  logic              valid_q;
  cl_pkg::host_req_t req_q;
  logic              s_fire;

  // Room when empty or when the held entry drains this cycle
  assign s_ready_o = !valid_q || m_ready_i;
  assign s_fire    = s_valid_i && s_ready_o;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      valid_q <= 1'b0;
    end else if (s_fire) begin
      valid_q <= 1'b1;
    end else if (m_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload stage
  always_ff @(posedge clk_main_a0) begin
    if (s_fire) begin
      req_q <= s_req_i;
    end
  end

  assign m_valid_o = valid_q;
  assign m_req_o   = req_q;

  a_m_req_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_req_o));

endmodule

`default_nettype wire

// File: cl_status.sv
/* Virtual DIP synchronizer and virtual LED register */
`timescale 1ns/1ps
`default_nettype none

`include "cl_consts.svh"

module cl_status (
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  logic [15:0] status_vdip_i,
  output logic [15:0] status_vled_o,
  output logic [15:0] vdip_sync_o
);

  logic [15:0] vdip_q1;
  logic [15:0] vdip_q2;
  logic [15:0] vled_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1       <= 16'h0000;
      vdip_q2       <= 16'h0000;
      vled_q        <= 16'h0000;
      status_vled_o <= 16'h0000;
    end else begin
      // Two-flop DIP synchronizer
      vdip_q1       <= status_vdip_i;
      vdip_q2       <= vdip_q1;
      // LED word, then one output stage
      vled_q        <= `CL_VLED_PATTERN;
      status_vled_o <= vled_q;
    end
  end

  assign vdip_sync_o = vdip_q2;

  // LED output holds its pattern for the rest of the run
  a_vled_steady: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    status_vled_o == `CL_VLED_PATTERN |=> status_vled_o == `CL_VLED_PATTERN);

endmodule

`default_nettype wire

// File: cl_pkg.sv
/* Host and memory request/response types, region and CSR codes, host address union */
`default_nettype none

`include "cl_consts.svh"

package cl_pkg;

  typedef enum logic [1:0] {
    REGION_ROM     = 2'd0,
    REGION_CSR     = 2'd1,
    REGION_UNMAP_A = 2'd2,
    REGION_UNMAP_B = 2'd3
  } host_region_e;

  typedef enum logic [3:0] {
    CSR_ID0     = 4'd0,
    CSR_ID1     = 4'd1,
    CSR_DIP     = 4'd2,
    CSR_LED     = 4'd3,
    CSR_SCRATCH = 4'd4
  } csr_sel_e;

  // ----------------------------------------
  // Host address, same region bits in both views
  // ----------------------------------------
  typedef struct packed {
    host_region_e                  region;
    logic [`CL_HOST_ADDR_W-11:0]   unused;
    logic [7:0]                    index;
  } rom_view_t;

  typedef struct packed {
    host_region_e                  region;
    logic [`CL_HOST_ADDR_W-7:0]    unused;
    logic [3:0]                    reg_sel;
  } csr_view_t;

  typedef union packed {
    rom_view_t rom_view;
    csr_view_t csr_view;
  } host_addr_u;

  typedef struct packed {
    host_addr_u                  addr;
    logic [`CL_HOST_DATA_W-1:0]  wdata;
    logic                        write;
  } host_req_t;

  typedef struct packed {
    logic [`CL_HOST_DATA_W-1:0]  rdata;
    logic                        err;
  } host_rsp_t;

  // ----------------------------------------
  // Memory port
  // ----------------------------------------
  typedef struct packed {
    logic [`CL_MEM_ADDR_W-1:0]  addr;
    logic [`CL_MEM_DATA_W-1:0]  wdata;
    logic                       write;
    logic [`CL_MEM_TAG_W-1:0]   tag;
  } mem_req_t;

  typedef struct packed {
    logic [`CL_MEM_DATA_W-1:0]  rdata;
    logic [`CL_MEM_TAG_W-1:0]   tag;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: cl_consts.svh
/* Width, identification, LED, ROM and memory issue-depth constants */
`ifndef CL_CONSTS_SVH
`define CL_CONSTS_SVH

// Host register port
`define CL_HOST_ADDR_W 16
`define CL_HOST_DATA_W 32

// Shared memory port
`define CL_MEM_ADDR_W 32
`define CL_MEM_DATA_W 64
`define CL_MEM_TAG_W 4
`define CL_MEM_ISSUE_DEPTH 4

// Identification and status
`define CL_ID0 32'hF001_1D0F
`define CL_ID1 32'h1D51_FEDC
`define CL_VLED_PATTERN 16'hBEEF

// Configuration ROM
`define CL_ROM_TAG 16'hC0F9
`define CL_ROM_ELS 32

`endif
